// ==== logic/gloves_pkg.sv ====
// screen limits, cross geometry, tick counts, colours and shared struct and enum types
`default_nettype none

package gloves_pkg;

    // visible area
    localparam int H_MAX = 1023;
    localparam int V_MAX = 767;

    // a shot exactly on an edge is a miss
    localparam int GOAL_EDGE_X = 1000;
    localparam int GOAL_EDGE_Y = 738;

    // cross box and diagonal thickness
    localparam int CROSS_WIDTH = 100;
    localparam int LINE_WIDTH  = 2;

    // durations in ms ticks
    localparam int COUNTDOWN_TICKS = 500;
    localparam int SHOW_TICKS      = 250;
    localparam int TERMINATE_TICKS = 250;

    localparam int TICKS_DEFAULT_CYCLES = 65000; // 1 ms at 65 MHz

    localparam logic [11:0] AIM_COLOR  = 12'h0_0_F;
    localparam logic [11:0] GOAL_COLOR = 12'hF_0_0;
    localparam logic [11:0] SAVE_COLOR = 12'h0_F_0;

    // shot target in screen pixels
    typedef struct packed {
        logic [9:0] x;
        logic [9:0] y;
    } shot_t;

    // keeper glove position
    typedef struct packed {
        logic [11:0] x;
        logic [11:0] y;
    } glove_t;

    // one pixel of the vga stream
    typedef struct packed {
        logic [10:0] hcount;
        logic [10:0] vcount;
        logic        hsync;
        logic        vsync;
        logic        hblnk;
        logic        vblnk;
        logic [11:0] rgb;
    } video_t;

    // overlay colour selector
    typedef enum logic [1:0] {
        MARK_NONE,
        MARK_AIM,
        MARK_GOAL,
        MARK_SAVE
    } mark_t;

endpackage

`default_nettype wire

// ==== logic/round_fsm.sv ====
// round state machine with shot handshake, clamp, ms tick and result decision
`timescale 1ns/1ps
`default_nettype none

module round_fsm #(
    parameter int CYCLES_PER_TICK = gloves_pkg::TICKS_DEFAULT_CYCLES
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               keeper_active,
    input  logic               shot_req,
    input  gloves_pkg::shot_t  shot,
    output logic               shot_ack,
    input  gloves_pkg::glove_t glove,
    output gloves_pkg::shot_t  target,
    output gloves_pkg::mark_t  mark,
    output logic               is_scored,
    output logic               round_done,
    output logic               end_gk
);
    import gloves_pkg::*;

    localparam int PRESC_W   = $clog2(CYCLES_PER_TICK + 1);
    localparam int SHOW_MAX  = (SHOW_TICKS > TERMINATE_TICKS) ? SHOW_TICKS : TERMINATE_TICKS;
    localparam int MAX_TICKS = (COUNTDOWN_TICKS > SHOW_MAX) ? COUNTDOWN_TICKS : SHOW_MAX;
    localparam int TICK_W    = $clog2(MAX_TICKS + 1);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_ENGAGE,
        ST_ACK,       // ack high, waiting for req to drop
        ST_COUNTDOWN,
        ST_RESULT,
        ST_GOAL,
        ST_SAVE,
        ST_TERMINATE
    } state_t;

    state_t state;
    state_t state_nxt;

    logic [PRESC_W-1:0] presc;
    logic               tick;
    logic [TICK_W-1:0]  tick_cnt;
    logic [TICK_W-1:0]  tick_limit;
    logic               time_up;

    shot_t       shot_clamped;
    logic [11:0] box_x_hi;
    logic [11:0] box_y_hi;
    logic        on_edge;
    logic        in_box;

    assign tick = (presc == PRESC_W'(CYCLES_PER_TICK - 1));

    // last tick index of the timed states
    always_comb begin
        case (state)
            ST_COUNTDOWN:     tick_limit = TICK_W'(COUNTDOWN_TICKS - 1);
            ST_GOAL, ST_SAVE: tick_limit = TICK_W'(SHOW_TICKS - 1);
            default:          tick_limit = TICK_W'(TERMINATE_TICKS - 1);
        endcase
    end

    assign time_up = tick && (tick_cnt == tick_limit);

    always_comb begin
        shot_clamped = shot;
        if (shot.x > H_MAX)
            shot_clamped.x = 10'(H_MAX);
        if (shot.y > V_MAX)
            shot_clamped.y = 10'(V_MAX);
    end

    // glove inside the cross box means a save
    assign box_x_hi = 12'(target.x) + 12'(CROSS_WIDTH);
    assign box_y_hi = 12'(target.y) + 12'(CROSS_WIDTH);
    assign in_box   = (glove.x >= 12'(target.x)) && (glove.x <= box_x_hi) &&
                      (glove.y >= 12'(target.y)) && (glove.y <= box_y_hi);

    assign on_edge = (target.x == '0) || (target.x == 10'(GOAL_EDGE_X)) ||
                     (target.y == '0) || (target.y == 10'(GOAL_EDGE_Y));

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (keeper_active)
                    state_nxt = ST_ENGAGE;
            end
            ST_ENGAGE: begin
                if (!keeper_active)
                    state_nxt = ST_IDLE;
                else if (shot_req)
                    state_nxt = ST_ACK;
            end
            ST_ACK: begin
                if (!shot_req)
                    state_nxt = ST_COUNTDOWN;
            end
            ST_COUNTDOWN: begin
                if (time_up)
                    state_nxt = ST_RESULT;
            end
            ST_RESULT: begin
                if (on_edge || in_box)
                    state_nxt = ST_SAVE;
                else
                    state_nxt = ST_GOAL;
            end
            ST_GOAL, ST_SAVE: begin
                if (time_up)
                    state_nxt = ST_TERMINATE;
            end
            ST_TERMINATE: begin
                if (time_up)
                    state_nxt = ST_IDLE;
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= ST_IDLE;
            presc      <= '0;
            tick_cnt   <= '0;
            shot_ack   <= 1'b0;
            mark       <= MARK_NONE;
            is_scored  <= 1'b0;
            round_done <= 1'b0;
            end_gk     <= 1'b0;
        end else begin
            state <= state_nxt;
            presc <= tick ? '0 : presc + 1'b1; // free running, phase not reset

            if (state_nxt != state)
                tick_cnt <= '0;
            else if (tick)
                tick_cnt <= tick_cnt + 1'b1;

            shot_ack   <= (state_nxt == ST_ACK);
            is_scored  <= (state_nxt == ST_GOAL);
            round_done <= (state_nxt == ST_GOAL) || (state_nxt == ST_SAVE);
            end_gk     <= (state == ST_TERMINATE) && (state_nxt == ST_IDLE);

            case (state_nxt)
                ST_COUNTDOWN, ST_RESULT: mark <= MARK_AIM;
                ST_GOAL:                 mark <= MARK_GOAL;
                ST_SAVE:                 mark <= MARK_SAVE;
                default:                 mark <= MARK_NONE;
            endcase
        end
    end

    // shot saved on the ack edge
    always_ff @(posedge clk) begin
        if ((state == ST_ENGAGE) && (state_nxt == ST_ACK))
            target <= shot_clamped;
    end

    // ack only ever answers a pending request
    assert property (@(posedge clk) disable iff (rst)
        $rose(shot_ack) |-> $past(shot_req));

    assert property (@(posedge clk) disable iff (rst)
        is_scored |-> round_done);

endmodule

`default_nettype wire

// ==== logic/video_delay.sv ====
// fixed-depth register pipeline for the video struct
`timescale 1ns/1ps
`default_nettype none

module video_delay #(
    parameter int DEPTH = 2
) (
    input  logic               clk,
    input  logic               rst,
    input  gloves_pkg::video_t din,
    output gloves_pkg::video_t dout
);
    import gloves_pkg::*;

    video_t pipe [DEPTH];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                pipe[i] <= '0;
            end
        end else begin
            pipe[0] <= din;
            for (int i = 1; i < DEPTH; i++) begin
                pipe[i] <= pipe[i-1];
            end
        end
    end

    assign dout = pipe[DEPTH-1]; // sync and blank stay aligned with overlay

endmodule

`default_nettype wire

// ==== logic/cross_overlay.sv ====
// two-stage pixel pipeline that detects the cross and replaces the colour
`timescale 1ns/1ps
`default_nettype none

module cross_overlay (
    input  logic               clk,
    input  logic               rst,
    input  gloves_pkg::video_t video_in,
    input  gloves_pkg::video_t video_dly,
    input  gloves_pkg::shot_t  target,
    input  gloves_pkg::mark_t  mark,
    output gloves_pkg::video_t video_out
);
    import gloves_pkg::*;

    logic signed [11:0] dx;
    logic signed [11:0] dy;
    logic signed [12:0] diff;
    logic signed [12:0] sum;
    logic               in_box;
    logic               on_diag;
    logic               on_cross;
    logic [11:0]        mark_color;

    logic        hit_s1;
    logic [11:0] color_s1;
    logic        hit_s2;
    logic [11:0] color_s2;

    // offsets from the top left corner of the box
    assign dx = $signed({1'b0, video_in.hcount}) - $signed({2'b00, target.x});
    assign dy = $signed({1'b0, video_in.vcount}) - $signed({2'b00, target.y});

    assign diff = 13'(dx) - 13'(dy);
    assign sum  = 13'(dx) + 13'(dy);

    assign in_box = (dx >= 0) && (dx <= CROSS_WIDTH) && (dy >= 0) && (dy <= CROSS_WIDTH);

    // falling and rising diagonal
    assign on_diag = ((diff >= 0) && (diff <= LINE_WIDTH)) ||
                     ((sum >= CROSS_WIDTH) && (sum <= CROSS_WIDTH + LINE_WIDTH));

    assign on_cross = in_box && on_diag;

    always_comb begin
        case (mark)
            MARK_AIM:  mark_color = AIM_COLOR;
            MARK_GOAL: mark_color = GOAL_COLOR;
            MARK_SAVE: mark_color = SAVE_COLOR;
            default:   mark_color = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hit_s1 <= 1'b0;
            hit_s2 <= 1'b0;
        end else begin
            hit_s1 <= on_cross && (mark != MARK_NONE); // low means pass through
            hit_s2 <= hit_s1;
        end
    end

    always_ff @(posedge clk) begin
        color_s1 <= mark_color;
        color_s2 <= color_s1;
    end

    // stage two lines up with the delayed stream
    always_comb begin
        video_out = video_dly;
        if (hit_s2)
            video_out.rgb = color_s2;
    end

    // sync must come out exactly two cycles after it went in
    assert property (@(posedge clk) disable iff (rst)
        !$past(rst) && !$past(rst, 2) |->
        ({video_out.hsync, video_out.vsync} == $past({video_in.hsync, video_in.vsync}, 2)));

endmodule

`default_nettype wire

// ==== logic/gloves_control_top.sv ====
// top level joining round fsm, video delay and cross overlay
`timescale 1ns/1ps
`default_nettype none

module gloves_control_top #(
    parameter int CYCLES_PER_TICK = gloves_pkg::TICKS_DEFAULT_CYCLES
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               keeper_active,
    input  logic               shot_req,
    input  gloves_pkg::shot_t  shot,
    output logic               shot_ack,
    input  gloves_pkg::glove_t glove,
    input  gloves_pkg::video_t video_in,
    output gloves_pkg::video_t video_out,
    output logic               is_scored,
    output logic               round_done,
    output logic               end_gk
);
    import gloves_pkg::*;

    shot_t  target;
    mark_t  mark;
    video_t video_dly;

    round_fsm #(
        .CYCLES_PER_TICK(CYCLES_PER_TICK)
    ) u_round_fsm (
        .clk,
        .rst,
        .keeper_active,
        .shot_req,
        .shot,
        .shot_ack,
        .glove,
        .target,
        .mark,
        .is_scored,
        .round_done,
        .end_gk
    );

    // matches the two overlay stages
    video_delay #(
        .DEPTH(2)
    ) u_video_delay (
        .clk,
        .rst,
        .din  (video_in),
        .dout (video_dly)
    );

    cross_overlay u_cross_overlay (
        .clk,
        .rst,
        .video_in,
        .video_dly,
        .target,
        .mark,
        .video_out
    );

endmodule

`default_nettype wire

// ==== testbench/gloves_checks.svh ====
// typed compare tasks and pass/fail counters for the gloves testbench
`ifndef GLOVES_CHECKS_SVH
`define GLOVES_CHECKS_SVH

localparam int NAME_W  = 8 * 24;
localparam int LABEL_W = 8 * 16;

int error_count     = 0;
int test_count      = 0;
int failed_tests    = 0;
int errors_at_start = 0;

task automatic start_test();
    errors_at_start = error_count;
    test_count++;
endtask

// one line per finished test
task automatic end_test(input logic [NAME_W-1:0] test_name);
    if (error_count == errors_at_start) begin
        $display("%0s: pass", test_name);
    end else begin
        failed_tests++;
        $display("%0s: fail with %0d errors", test_name, error_count - errors_at_start);
    end
endtask

task automatic check_flag(input logic [NAME_W-1:0] test_name, input logic [LABEL_W-1:0] what,
                          input logic expected, input logic actual);
    if (actual !== expected) begin
        error_count++;
        $display("Mismatch %0s %0s: expected %b, actual %b", test_name, what, expected, actual);
    end
endtask

task automatic check_shot(input logic [NAME_W-1:0] test_name, input shot_t expected,
                          input shot_t actual);
    if (actual !== expected) begin
        error_count++;
        $display("Mismatch %0s target: expected (%0d,%0d), actual (%0d,%0d)", test_name,
                 expected.x, expected.y, actual.x, actual.y);
    end
endtask

task automatic check_video(input logic [NAME_W-1:0] test_name, input video_t expected,
                           input video_t actual);
    if (actual !== expected) begin
        error_count++;
        $display("Mismatch %0s video: expected %h, actual %h", test_name, expected, actual);
    end
endtask

`endif

// ==== testbench/gloves_control_tb.sv ====
// testbench for gloves_control_top with handshake driver, cross sweeps and round sequencing
`timescale 1ns/1ps
`default_nettype none

module gloves_control_tb;
    import gloves_pkg::*;

    `include "gloves_checks.svh"

    localparam int TICK_CYCLES = 4;
    localparam int SIG_ACK     = 0;
    localparam int SIG_DONE    = 1;
    localparam int SIG_END     = 2;

    logic   clk;
    logic   rst;
    logic   keeper_active;
    logic   shot_req;
    shot_t  shot;
    logic   shot_ack;
    glove_t glove;
    video_t video_in;
    video_t video_out;
    logic   is_scored;
    logic   round_done;
    logic   end_gk;

    integer seed = 32'h7f4b9e83;
    integer fd;
    int     got;
    int     row_sx;
    int     row_sy;
    int     row_gx;
    int     row_gy;
    int     row_scored;
    bit     timed_out = 1'b0;
    logic [8*128-1:0]  text_line;
    logic [NAME_W-1:0] test_name;

    gloves_control_top #(
        .CYCLES_PER_TICK(TICK_CYCLES)
    ) u_gloves_control_top (
        .clk, .rst, .keeper_active, .shot_req, .shot, .shot_ack, .glove,
        .video_in, .video_out, .is_scored, .round_done, .end_gk
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic next_cycle();
        @(posedge clk);
        #10; // drive and sample point
    endtask

    task automatic finish_run();
        $display("tests %0d, passed %0d, failed %0d, errors %0d", test_count,
                 test_count - failed_tests, failed_tests, error_count);
        if (error_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    function automatic logic probe(input int which);
        case (which)
            SIG_ACK:  return shot_ack;
            SIG_DONE: return round_done;
            default:  return end_gk;
        endcase
    endfunction

    function automatic string probe_name(input int which);
        case (which)
            SIG_ACK:  return "shot_ack";
            SIG_DONE: return "round_done";
            default:  return "end_gk";
        endcase
    endfunction

    task automatic wait_level(input logic [NAME_W-1:0] name, input int which,
                              input logic level, input int limit);
        int n;
        n = 0;
        while (probe(which) !== level && n < limit) begin
            next_cycle();
            n++;
        end
        if (probe(which) !== level) begin
            error_count++;
            timed_out = 1'b1;
            $display("%0s: %0s did not go to %b within %0d cycles",
                     name, probe_name(which), level, limit);
        end
    endtask

    // cross rule: inside the box and on one of the two diagonals
    function automatic logic on_cross(input video_t v, input shot_t t);
        int dx;
        int dy;
        dx = int'(v.hcount) - int'(t.x);
        dy = int'(v.vcount) - int'(t.y);
        if (dx < 0 || dx > CROSS_WIDTH || dy < 0 || dy > CROSS_WIDTH)
            return 1'b0;
        return ((dx - dy >= 0) && (dx - dy <= LINE_WIDTH)) ||
               ((dx + dy >= CROSS_WIDTH) && (dx + dy <= CROSS_WIDTH + LINE_WIDTH));
    endfunction

    task automatic make_pixel(input int h, input int v, output video_t px);
        logic [31:0] r;
        r = $random(seed);
        px.hcount = 11'(h);
        px.vcount = 11'(v);
        {px.hsync, px.vsync, px.hblnk, px.vblnk} = r[15:12];
        px.rgb = r[11:0];
        if (px.rgb == AIM_COLOR || px.rgb == GOAL_COLOR || px.rgb == SAVE_COLOR)
            px.rgb = px.rgb ^ 12'h001; // so a mark colour always means overlay
    endtask

    // sweeps rows around the target, compares every output two cycles later
    task automatic sweep_cross(input logic [NAME_W-1:0] name, input shot_t t,
                               input logic [11:0] color, output shot_t first_hit);
        video_t pixels [$];
        video_t pending [$];
        video_t px;
        video_t exp_px;
        int     rows [7];
        logic   found;
        rows = '{-1, 0, 1, 50, 99, 100, 101};
        found = 1'b0;
        first_hit = '1;
        for (int r = 0; r < 7; r++) begin
            for (int dx = -2; dx <= CROSS_WIDTH + 3; dx++) begin
                make_pixel(int'(t.x) + dx, int'(t.y) + rows[r], px);
                pixels.push_back(px);
            end
        end
        px = '0;
        px.hcount = '1; // far off any cross
        px.vcount = '1;
        pixels.push_back(px);
        pixels.push_back(px);
        foreach (pixels[i]) begin
            next_cycle();
            if (pending.size() == 2) begin
                exp_px = pending.pop_front();
                check_video(name, exp_px, video_out);
                if (!found && video_out.rgb == color) begin
                    found = 1'b1;
                    first_hit = {video_out.hcount[9:0], video_out.vcount[9:0]};
                end
            end
            video_in = pixels[i];
            exp_px = pixels[i];
            if (on_cross(pixels[i], t))
                exp_px.rgb = color;
            pending.push_back(exp_px);
        end
    endtask

    task automatic play_round(input logic [NAME_W-1:0] name, input int shot_x, input int shot_y,
                              input int glove_x, input int glove_y, input int scored);
        shot_t       t;
        shot_t       hit;
        logic [11:0] result_color;
        t.x = 10'((shot_x > H_MAX) ? H_MAX : shot_x);
        t.y = 10'((shot_y > V_MAX) ? V_MAX : shot_y);
        result_color = (scored != 0) ? GOAL_COLOR : SAVE_COLOR;
        start_test();
        shot.x = 10'(shot_x);
        shot.y = 10'(shot_y);
        glove.x = 12'(glove_x);
        glove.y = 12'(glove_y);
        shot_req = 1'b1;
        wait_level(name, SIG_ACK, 1'b1, 20);
        if (!timed_out) begin
            repeat (3) begin
                next_cycle();
                check_flag(name, "ack_hold", 1'b1, shot_ack);
            end
            shot_req = 1'b0;
            wait_level(name, SIG_ACK, 1'b0, 5);
        end
        if (!timed_out) begin
            sweep_cross(name, t, AIM_COLOR, hit);
            check_shot(name, t, hit);
            wait_level(name, SIG_DONE, 1'b1, COUNTDOWN_TICKS * TICK_CYCLES + 50);
        end
        if (!timed_out) begin
            check_flag(name, "is_scored", scored != 0, is_scored);
            sweep_cross(name, t, result_color, hit);
            check_shot(name, t, hit);
            wait_level(name, SIG_DONE, 1'b0, SHOW_TICKS * TICK_CYCLES + 50);
        end
        if (!timed_out)
            wait_level(name, SIG_END, 1'b1, TERMINATE_TICKS * TICK_CYCLES + 50);
        if (!timed_out) begin
            next_cycle();
            check_flag(name, "end_gk_width", 1'b0, end_gk);
            check_flag(name, "ack_after", 1'b0, shot_ack);
            check_flag(name, "scored_after", 1'b0, is_scored);
            check_flag(name, "done_after", 1'b0, round_done);
        end
        shot_req = 1'b0;
        end_test(name);
    endtask

    initial begin
        rst = 1'b1;
        keeper_active = 1'b0;
        shot_req = 1'b0;
        shot = '0;
        glove = '0;
        video_in = '0;
        repeat (4) @(posedge clk);
        #10;
        rst = 1'b0;

        test_name = "reset";
        start_test();
        check_flag(test_name, "shot_ack", 1'b0, shot_ack);
        check_flag(test_name, "is_scored", 1'b0, is_scored);
        check_flag(test_name, "round_done", 1'b0, round_done);
        check_flag(test_name, "end_gk", 1'b0, end_gk);
        check_video(test_name, '0, video_out);
        end_test(test_name);

        // request with the keeper inactive stays unanswered
        test_name = "ack_gate";
        start_test();
        shot.x = 10'd300;
        shot.y = 10'd300;
        shot_req = 1'b1;
        repeat (20) begin
            next_cycle();
            check_flag(test_name, "shot_ack", 1'b0, shot_ack);
        end
        shot_req = 1'b0;
        keeper_active = 1'b1;
        end_test(test_name);

        fd = $fopen("testbench/gloves_testdata.txt", "r");
        if (fd == 0) begin
            error_count++;
            $display("could not open testbench/gloves_testdata.txt");
        end else begin
            while (!$feof(fd) && !timed_out) begin
                text_line = '0;
                got = $fgets(text_line, fd);
                got = $sscanf(text_line, "%s %d %d %d %d %d", test_name, row_sx, row_sy,
                              row_gx, row_gy, row_scored);
                if (got == 6)
                    play_round(test_name, row_sx, row_sy, row_gx, row_gy, row_scored);
            end
            $fclose(fd);
        end
        if (test_count < 3) begin
            error_count++;
            $display("no rounds were read from the data file");
        end
        finish_run();
    end

endmodule

`default_nettype wire

// ==== testbench/gloves_testdata.txt ====
# name shot_x shot_y glove_x glove_y is_scored (all decimal)
# shot y above 767 is clamped before the result is decided
center_save 400 300 450 350 0
center_goal 400 300 600 350 1
box_corner_save 200 100 300 200 0
box_outside_goal 200 100 301 200 1
edge_x_miss 1000 300 0 0 0
edge_y_miss 500 738 0 0 0
zero_x_miss 0 400 900 900 0
clamp_y_goal 700 900 10 10 1
clamp_y_save 100 1000 150 800 0
glove_left_goal 600 500 599 550 1

// ==== gloves_control.f ====
+incdir+testbench
logic/gloves_pkg.sv
logic/round_fsm.sv
logic/video_delay.sv
logic/cross_overlay.sv
logic/gloves_control_top.sv
testbench/gloves_control_tb.sv
